// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_genesis_bus
FILES     ?= tb.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILES)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_genesis_bus.sv
// Self-checking testbench for the bus fabric; compile with the RTL through tb.f and run the binary
module tb_genesis_bus import genesis_bus_pkg::*;;
	timeunit 1ns;
	timeprecision 100ps;

	// Cycle budgets per test, the watchdog allows four times their sum
	localparam int CE_LEN   = 60;
	localparam int WRAM_LEN = 800;
	localparam int CTRL_LEN = 120;
	localparam int ZRAM_LEN = 450;
	localparam int BANK_LEN = 450;
	localparam int CONT_LEN = 750;
	localparam int TEST_LEN = CE_LEN + WRAM_LEN + CTRL_LEN + ZRAM_LEN + BANK_LEN + CONT_LEN;

	logic      MCLK = 1'b0;
	logic      reset;
	mbus_req_t main_req;
	logic      main_ready;
	mbus_rsp_t main_rsp;
	z80_req_t  z80_req;
	logic      z80_ready;
	z80_rsp_t  z80_rsp;
	cpu_ce_t   ce;
	z80_ctl_t  z80_ctl;

	int errors = 0;
	int checks = 0;
	int seed = 60;
	int m_gap, z_gap;
	logic m_seen, z_seen;
	int main_xfers = 0, main_rsps = 0, z80_xfers = 0, z80_rsps = 0;

	// Reference models
	logic [15:0]       wram_m [0:(1 << WRAM_ADDR_W) - 1];
	logic [7:0]        zram_m [0:(1 << ZRAM_ADDR_W) - 1];
	logic [BANK_W-1:0] bank_m;

	genesis_bus_top uut (
		.MCLK,
		.reset,
		.main_req,
		.main_ready,
		.main_rsp,
		.z80_req,
		.z80_ready,
		.z80_rsp,
		.ce,
		.z80_ctl
	);

	always #50 MCLK = ~MCLK;

	// --------------------------------------------------
	// Concurrent checks
	// --------------------------------------------------
	assert property (@(posedge MCLK) disable iff (reset) ce.m68k |=> !ce.m68k)
	else begin
		$display("68000 enable was high for two cycles at %0t", $time);
		errors++;
	end

	assert property (@(posedge MCLK) disable iff (reset) ce.z80 |=> !ce.z80)
	else begin
		$display("Z80 enable was high for two cycles at %0t", $time);
		errors++;
	end

	assert property (@(posedge MCLK) disable iff (reset) z80_ctl.busreq |-> !z80_ready)
	else begin
		$display("Z80 port was ready while the main side held the bus at %0t", $time);
		errors++;
	end

	// Enable period tracking and transfer/response counting
	always @(posedge MCLK) begin
		if (reset) begin
			m_gap  <= 0;
			z_gap  <= 0;
			m_seen <= 1'b0;
			z_seen <= 1'b0;
		end else begin
			m_gap <= ce.m68k ? 1 : m_gap + 1;
			z_gap <= ce.z80 ? 1 : z_gap + 1;
			if (ce.m68k) begin
				m_seen <= 1'b1;
				if (m_seen)
					check32("ce.m68k period", M68K_CE_DIV, m_gap);
			end
			if (ce.z80) begin
				z_seen <= 1'b1;
				if (z_seen)
					check32("ce.z80 period", Z80_CE_DIV, z_gap);
			end
			if (main_ready && main_req.valid)
				main_xfers++;
			if (main_rsp.valid)
				main_rsps++;
			if (z80_ready && z80_req.valid)
				z80_xfers++;
			if (z80_rsp.valid)
				z80_rsps++;
		end
	end

	task automatic check32(input string name, input int exp, input int got);
		checks++;
		assert (got == exp)
		else begin
			$display("FAILED at %0t: %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic check16(input string name, input logic [15:0] exp, input logic [15:0] got);
		checks++;
		assert (got === exp)
		else begin
			$display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Bus access tasks
	// --------------------------------------------------
	task automatic main_access(input logic wr, input logic ub, input logic lb,
		input logic [23:0] addr, input logic [15:0] wd, output logic [15:0] rd);
		@(posedge MCLK);
		main_req <= '{valid: 1'b1, write: wr, ube: ub, lbe: lb, addr: addr, wdata: wd};
		do @(negedge MCLK); while (!main_ready);
		@(posedge MCLK);
		main_req.valid <= 1'b0;
		do @(negedge MCLK); while (!main_rsp.valid);
		rd = main_rsp.rdata;
	endtask

	task automatic z80_access(input logic wr, input logic [15:0] addr, input logic [7:0] wd,
		output logic [7:0] rd);
		@(posedge MCLK);
		z80_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wd};
		do @(negedge MCLK); while (!z80_ready);
		@(posedge MCLK);
		z80_req.valid <= 1'b0;
		do @(negedge MCLK); while (!z80_rsp.valid);
		rd = z80_rsp.rdata;
	endtask

	// Model update for a lane write
	task automatic wram_write(input logic ub, input logic lb, input logic [23:0] addr,
		input logic [15:0] wd);
		logic [15:0] rd;
		main_access(1'b1, ub, lb, addr, wd, rd);
		if (ub)
			wram_m[addr[15:1]][15:8] = wd[15:8];
		if (lb)
			wram_m[addr[15:1]][7:0] = wd[7:0];
	endtask

	task automatic wram_read_check(input logic [23:0] addr);
		logic [15:0] rd;
		main_access(1'b0, 1'b1, 1'b1, addr, 16'h0, rd);
		check16("main_rsp.rdata", wram_m[addr[15:1]], rd);
	endtask

	task automatic window_access(input logic wr, input logic [14:0] off, input logic [7:0] wd);
		logic [7:0]  rd;
		logic [14:0] idx;
		idx = {bank_m[0], off[14:1]};
		z80_access(wr, {1'b1, off}, wd, rd);
		if (wr && !off[0])
			wram_m[idx][15:8] = wd;
		else if (wr)
			wram_m[idx][7:0] = wd;
		else
			check16("z80_rsp.rdata", {8'h0, off[0] ? wram_m[idx][7:0] : wram_m[idx][15:8]},
				{8'h0, rd});
	endtask

	task automatic test_done(input string name);
		$display("%-12s done, %0d errors so far", name, errors);
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		logic [23:0] addrs [16];
		logic [15:0] rd;
		logic [7:0]  zb;
		logic [12:0] zoff [8];
		logic [14:0] off;

		reset    = 1'b1;
		main_req = '0;
		z80_req  = '0;
		bank_m   = '0;
		repeat (8) @(posedge MCLK);
		reset <= 1'b0;

		repeat (CE_LEN) @(posedge MCLK);
		test_done("clk_enable");

		// Full words first so partial writes have a known base
		foreach (addrs[i]) begin
			addrs[i] = 24'hE00000 | {8'h0, $random(seed)} & 24'h00FFFE;
			wram_write(1'b1, 1'b1, addrs[i], $random(seed));
		end
		foreach (addrs[i]) begin
			rd = $random(seed);
			wram_write(rd[0], rd[1], addrs[i], $random(seed));
		end
		foreach (addrs[i]) begin
			wram_read_check(addrs[i]);
			wram_read_check(addrs[i] + 24'h010000);
		end
		main_access(1'b0, 1'b1, 1'b1, 24'h400000, 16'h0, rd);
		check16("unmapped rdata", 16'h0000, rd);
		test_done("work_ram");

		main_access(1'b0, 1'b1, 1'b1, 24'hA11100, 16'h0, rd);
		check16("A11100 rdata", 16'h0100, rd);
		main_access(1'b0, 1'b1, 1'b1, 24'hA11200, 16'h0, rd);
		check16("A11200 rdata", 16'h0000, rd);
		main_access(1'b0, 1'b1, 1'b1, 24'hA00000, 16'h0, rd);
		check16("zbus rdata", 16'hFFFF, rd);
		main_access(1'b1, 1'b1, 1'b0, 24'hA11200, 16'h0100, rd);
		check16("z80_ctl", 16'h0001, {14'h0, z80_ctl});
		main_access(1'b0, 1'b1, 1'b1, 24'hA11200, 16'h0, rd);
		check16("A11200 rdata", 16'h0100, rd);
		main_access(1'b0, 1'b1, 1'b1, 24'hA00010, 16'h0, rd);
		check16("zbus rdata", 16'hFFFF, rd);
		test_done("control");

		// Z80 RAM with run set and the bus held by the Z80
		for (int i = 0; i < 8; i++) begin
			zoff[i] = $random(seed);
			zb = $random(seed);
			z80_access(1'b1, {3'b000, zoff[i]}, zb, rd[7:0]);
			zram_m[zoff[i]] = zb;
		end
		for (int i = 0; i < 8; i++) begin
			z80_access(1'b0, {3'b000, zoff[i]}, 8'h0, zb);
			check16("z80_rsp.rdata", {8'h0, zram_m[zoff[i]]}, {8'h0, zb});
			z80_access(1'b0, {3'b001, zoff[i]}, 8'h0, zb);
			check16("z80_rsp.rdata mirror", {8'h0, zram_m[zoff[i]]}, {8'h0, zb});
		end
		main_access(1'b1, 1'b1, 1'b0, 24'hA11100, 16'h0100, rd);
		check16("z80_ctl", 16'h0003, {14'h0, z80_ctl});
		main_access(1'b0, 1'b1, 1'b1, 24'hA11100, 16'h0, rd);
		check16("A11100 rdata", 16'h0000, rd);
		repeat (20) @(posedge MCLK);
		for (int i = 0; i < 8; i++) begin
			main_access(1'b0, !zoff[i][0], zoff[i][0], 24'hA00000 | zoff[i], 16'h0, rd);
			check16("zbus rdata", {2{zram_m[zoff[i]]}}, rd);
		end
		main_access(1'b1, 1'b1, 1'b0, 24'hA11100, 16'h0000, rd);
		test_done("z80_ram");

		// Shift nine ones into the bank register
		repeat (BANK_W) begin
			z80_access(1'b1, 16'h6000, 8'h01, zb);
			bank_m = {1'b1, bank_m[BANK_W-1:1]};
		end
		for (int i = 0; i < 4; i++) begin
			off = $random(seed);
			wram_write(1'b1, 1'b1, {bank_m, off}, $random(seed));
			window_access(1'b0, off, 8'h0);
			window_access(1'b0, off ^ 15'h1, 8'h0);
			window_access(1'b1, off, $random(seed));
			wram_read_check({bank_m, off});
		end
		test_done("bank_window");

		// Main and window targets stay in disjoint halves of work RAM
		fork
			for (int i = 0; i < 12; i++) begin
				logic [23:0] a;
				a = 24'hE00000 | {8'h0, $random(seed)} & 24'h007FFE;
				wram_write(1'b1, 1'b1, a, $random(seed));
				wram_read_check(a);
			end
			for (int i = 0; i < 12; i++) begin
				logic [14:0] o;
				o = $random(seed);
				window_access(1'b1, o, $random(seed));
				window_access(1'b0, o, 8'h0);
			end
		join
		repeat (4) @(posedge MCLK);
		check32("main responses", main_xfers, main_rsps);
		check32("z80 responses", z80_xfers, z80_rsps);
		test_done("contention");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (TEST_LEN * 4) @(posedge MCLK);
		$display("Watchdog expired, a bus access never completed");
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src/clk_enable_gen.sv
// Clock-enable pulses for the 68000 and Z80 domains, one MCLK cycle wide each
module clk_enable_gen import genesis_bus_pkg::*; (
	input  logic    MCLK,
	input  logic    reset,
	output cpu_ce_t ce
);

	logic [$clog2(M68K_CE_DIV)-1:0] m68k_cnt;
	logic [$clog2(Z80_CE_DIV)-1:0]  z80_cnt;

	// Pulse registered on the terminal count
	always_ff @(posedge MCLK) begin
		if (reset) begin
			m68k_cnt <= '0;
			z80_cnt  <= '0;
			ce       <= '0;
		end else begin
			ce.m68k <= (m68k_cnt == M68K_CE_DIV - 1);
			ce.z80  <= (z80_cnt == Z80_CE_DIV - 1);

			if (m68k_cnt == M68K_CE_DIV - 1)
				m68k_cnt <= '0;
			else
				m68k_cnt <= m68k_cnt + 1'b1;

			if (z80_cnt == Z80_CE_DIV - 1)
				z80_cnt <= '0;
			else
				z80_cnt <= z80_cnt + 1'b1;
		end
	end

endmodule

// File: src/genesis_bus_pkg.sv
// Shared widths, clock divider constants, bus structs and FSM enums; import into each RTL module
package genesis_bus_pkg;

	// --------------------------------------------------
	// Widths and constants
	// --------------------------------------------------
	localparam int MAIN_ADDR_W = 24;
	localparam int MAIN_DATA_W = 16;
	localparam int Z80_ADDR_W  = 16;
	// Word address, mirrored across E00000-FFFFFF
	localparam int WRAM_ADDR_W = 15;
	// Byte address, mirrored twice in 0000-3FFF
	localparam int ZRAM_ADDR_W = 13;
	localparam int BANK_W      = 9;
	localparam int M68K_CE_DIV = 7;
	localparam int Z80_CE_DIV  = 15;

	// --------------------------------------------------
	// Request and response structs
	// --------------------------------------------------
	// Address bit 0 is ignored, lanes select the bytes
	typedef struct packed {
		logic                   valid;
		logic                   write;
		logic                   ube;
		logic                   lbe;
		logic [MAIN_ADDR_W-1:0] addr;
		logic [MAIN_DATA_W-1:0] wdata;
	} mbus_req_t;

	typedef struct packed {
		logic                   valid;
		logic [MAIN_DATA_W-1:0] rdata;
	} mbus_rsp_t;

	typedef struct packed {
		logic                  valid;
		logic                  write;
		logic [Z80_ADDR_W-1:0] addr;
		logic [7:0]            wdata;
	} z80_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] rdata;
	} z80_rsp_t;

	// Main side into Z80 bus, byte wide
	typedef struct packed {
		logic                  valid;
		logic                  write;
		logic [Z80_ADDR_W-2:0] addr;
		logic [7:0]            wdata;
	} zbus_req_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] rdata;
	} zbus_rsp_t;

	typedef struct packed {
		logic m68k;
		logic z80;
	} cpu_ce_t;

	// busreq: main side holds Z80 bus, run: Z80 out of reset
	typedef struct packed {
		logic busreq;
		logic run;
	} z80_ctl_t;

	// --------------------------------------------------
	// FSM encodings
	// --------------------------------------------------
	typedef enum logic [2:0] {MB_IDLE, MB_SELECT, MB_RAM_READ, MB_ZBUS_WAIT, MB_FINISH} mbus_state_e;
	typedef enum logic {SRC_MAIN, SRC_Z80} mbus_src_e;
	typedef enum logic [1:0] {REG_WRAM, REG_ZBUS, REG_CTRL, REG_NONE} mbus_region_e;
	typedef enum logic [1:0] {ZB_IDLE, ZB_READ, ZB_FINISH, ZB_WINDOW} zbus_state_e;

endpackage

// File: src/genesis_bus_top.sv
// Top of the bus fabric: clock enables, main bus, Z80 bus and the two work RAM byte lanes
module genesis_bus_top import genesis_bus_pkg::*; (
	input  logic      MCLK,
	input  logic      reset,
	input  mbus_req_t main_req,
	output logic      main_ready,
	output mbus_rsp_t main_rsp,
	input  z80_req_t  z80_req,
	output logic      z80_ready,
	output z80_rsp_t  z80_rsp,
	output cpu_ce_t   ce,
	output z80_ctl_t  z80_ctl
);

	mbus_req_t              win_req;
	logic                   win_ready;
	mbus_rsp_t              win_rsp;
	zbus_req_t              zb_req;
	zbus_rsp_t              zb_rsp;
	logic [WRAM_ADDR_W-1:0] wram_addr;
	logic [MAIN_DATA_W-1:0] wram_wdata;
	logic [MAIN_DATA_W-1:0] wram_rdata;
	logic                   wram_we_u;
	logic                   wram_we_l;

	clk_enable_gen ce_gen (
		.MCLK,
		.reset,
		.ce
	);

	mbus_fsm mbus (
		.MCLK,
		.reset,
		.ce,
		.main_req,
		.main_ready,
		.main_rsp,
		.win_req,
		.win_ready,
		.win_rsp,
		.zb_req,
		.zb_rsp,
		.z80_ctl,
		.wram_addr,
		.wram_wdata,
		.wram_we_u,
		.wram_we_l,
		.wram_rdata
	);

	zbus_ctrl zbus (
		.MCLK,
		.reset,
		.z80_req,
		.z80_ready,
		.z80_rsp,
		.zb_req,
		.zb_rsp,
		.z80_ctl,
		.win_req,
		.win_ready,
		.win_rsp
	);

	// --------------------------------------------------
	// 68000 work RAM, one instance per byte lane
	// --------------------------------------------------
	sync_ram #(.ADDR_W(WRAM_ADDR_W)) wram_hi (
		.MCLK,
		.addr  (wram_addr),
		.wdata (wram_wdata[15:8]),
		.we    (wram_we_u),
		.rdata (wram_rdata[15:8])
	);

	sync_ram #(.ADDR_W(WRAM_ADDR_W)) wram_lo (
		.MCLK,
		.addr  (wram_addr),
		.wdata (wram_wdata[7:0]),
		.we    (wram_we_l),
		.rdata (wram_rdata[7:0])
	);

endmodule

// File: src/mbus_fsm.sv
// Main-bus FSM: arbitrates 68000 port and Z80 window, decodes regions, holds Z80 control flags
module mbus_fsm import genesis_bus_pkg::*; (
	input  logic                   MCLK,
	input  logic                   reset,
	input  cpu_ce_t                ce,
	input  mbus_req_t              main_req,
	output logic                   main_ready,
	output mbus_rsp_t              main_rsp,
	input  mbus_req_t              win_req,
	output logic                   win_ready,
	output mbus_rsp_t              win_rsp,
	output zbus_req_t              zb_req,
	input  zbus_rsp_t              zb_rsp,
	output z80_ctl_t               z80_ctl,
	output logic [WRAM_ADDR_W-1:0] wram_addr,
	output logic [MAIN_DATA_W-1:0] wram_wdata,
	output logic                   wram_we_u,
	output logic                   wram_we_l,
	input  logic [MAIN_DATA_W-1:0] wram_rdata
);

	mbus_state_e            state;
	mbus_src_e              src;
	mbus_region_e           region;
	mbus_req_t              cur;
	logic [MAIN_DATA_W-1:0] data;
	logic                   main_take;
	logic                   ctl_bit;

	// --------------------------------------------------
	// Arbitration, main wins on its enable cycle
	// --------------------------------------------------
	assign main_ready = (state == MB_IDLE) && ce.m68k;
	assign main_take  = main_ready && main_req.valid;
	assign win_ready  = (state == MB_IDLE) && win_req.valid && !main_take;

	// Response pulse lasts the single FINISH cycle
	assign main_rsp.valid = (state == MB_FINISH) && (src == SRC_MAIN);
	assign main_rsp.rdata = data;
	assign win_rsp.valid  = (state == MB_FINISH) && (src == SRC_Z80);
	assign win_rsp.rdata  = data;

	// Work RAM sees the latched request, writes happen in SELECT
	assign wram_addr  = cur.addr[WRAM_ADDR_W:1];
	assign wram_wdata = cur.wdata;
	assign wram_we_u  = (state == MB_SELECT) && (region == REG_WRAM) && cur.write && cur.ube;
	assign wram_we_l  = (state == MB_SELECT) && (region == REG_WRAM) && cur.write && cur.lbe;

	// A11100 reads inverted busreq, A11200 reads run
	assign ctl_bit = cur.addr[8] ? !z80_ctl.busreq : z80_ctl.run;

	// --------------------------------------------------
	// Region decode
	// --------------------------------------------------
	always_comb begin
		region = REG_NONE;
		if (cur.addr[23:21] == 3'b111)
			region = REG_WRAM;
		else if (cur.addr[23:16] == 8'hA0 && src == SRC_MAIN)
			region = REG_ZBUS;
		else if (cur.addr[23:12] == 12'hA11 && cur.addr[7:1] == 7'd0 &&
				(cur.addr[11:8] == 4'h1 || cur.addr[11:8] == 4'h2))
			region = REG_CTRL;
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state        <= MB_IDLE;
			zb_req.valid <= 1'b0;
			z80_ctl      <= '0;
		end else begin
			case (state)
				MB_IDLE: begin
					if (main_take) begin
						cur   <= main_req;
						src   <= SRC_MAIN;
						state <= MB_SELECT;
					end else if (win_ready) begin
						cur   <= win_req;
						src   <= SRC_Z80;
						state <= MB_SELECT;
					end
				end

				MB_SELECT: begin
					case (region)
						REG_WRAM: state <= MB_RAM_READ;
						REG_ZBUS: begin
							// Upper lane is the even byte
							zb_req.valid <= 1'b1;
							zb_req.write <= cur.write;
							zb_req.addr  <= {cur.addr[14:1], !cur.ube};
							zb_req.wdata <= cur.ube ? cur.wdata[15:8] : cur.wdata[7:0];
							state        <= MB_ZBUS_WAIT;
						end
						REG_CTRL: begin
							data <= {7'd0, ctl_bit, 8'd0};
							if (cur.write && cur.ube) begin
								if (cur.addr[8])
									z80_ctl.busreq <= cur.wdata[8];
								else
									z80_ctl.run <= cur.wdata[8];
							end
							state <= MB_FINISH;
						end
						default: begin
							data  <= '0;
							state <= MB_FINISH;
						end
					endcase
				end

				MB_RAM_READ: begin
					data  <= wram_rdata;
					state <= MB_FINISH;
				end

				// Held until the Z80 bus answers
				MB_ZBUS_WAIT: begin
					if (zb_rsp.valid) begin
						zb_req.valid <= 1'b0;
						data         <= {zb_rsp.rdata, zb_rsp.rdata};
						state        <= MB_FINISH;
					end
				end

				default: state <= MB_IDLE;
			endcase
		end
	end

endmodule

// File: src/sync_ram.sv
// Single-port byte RAM, read data registered one cycle after the address
module sync_ram #(
	parameter int ADDR_W = 13
) (
	input  logic              MCLK,
	input  logic [ADDR_W-1:0] addr,
	input  logic [7:0]        wdata,
	input  logic              we,
	output logic [7:0]        rdata
);

	logic [7:0] mem [0:(1 << ADDR_W) - 1];

	// Read returns old contents on a write cycle
	always_ff @(posedge MCLK) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// File: src/zbus_ctrl.sv
// Z80-bus controller: owns Z80 RAM and the bank register, forwards Z80 window cycles to main bus
module zbus_ctrl import genesis_bus_pkg::*; (
	input  logic      MCLK,
	input  logic      reset,
	input  z80_req_t  z80_req,
	output logic      z80_ready,
	output z80_rsp_t  z80_rsp,
	input  zbus_req_t zb_req,
	output zbus_rsp_t zb_rsp,
	input  z80_ctl_t  z80_ctl,
	output mbus_req_t win_req,
	input  logic      win_ready,
	input  mbus_rsp_t win_rsp
);

	zbus_state_e           state;
	mbus_src_e             zsrc;
	logic [Z80_ADDR_W-2:0] zaddr;
	logic [7:0]            zwdata;
	logic                  zwrite;
	logic [BANK_W-1:0]     bank;
	logic [7:0]            ram_q;
	logic [7:0]            rd_byte;
	logic                  free;
	logic                  zb_pend;
	logic                  zb_take;
	logic                  z80_take;
	logic                  ram_sel;
	logic                  bank_sel;

	assign free = z80_ctl.busreq && z80_ctl.run;

	// Main keeps valid up on the cycle our response is out, so mask that cycle
	assign zb_pend = zb_req.valid && !zb_rsp.valid;

	// Main side may also cut in while the window request is still waiting for the main bus
	assign zb_take = zb_pend && (state == ZB_IDLE ||
		(state == ZB_WINDOW && win_req.valid && !win_ready));

	assign z80_ready = (state == ZB_IDLE) && z80_ctl.run && !z80_ctl.busreq && !zb_pend;
	assign z80_take  = z80_ready && z80_req.valid;

	// RAM at 0000-3FFF, bank register at 6000-60FF, all ones elsewhere
	assign ram_sel  = !zaddr[14];
	assign bank_sel = (zaddr[14:8] == 7'h60);
	assign rd_byte  = ram_sel ? ram_q : 8'hFF;

	sync_ram #(
		.ADDR_W(ZRAM_ADDR_W)
	) zram (
		.MCLK,
		.addr  (zaddr[ZRAM_ADDR_W-1:0]),
		.wdata (zwdata),
		.we    (state == ZB_READ && zwrite && ram_sel),
		.rdata (ram_q)
	);

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state         <= ZB_IDLE;
			bank          <= '0;
			win_req.valid <= 1'b0;
			z80_rsp.valid <= 1'b0;
			zb_rsp.valid  <= 1'b0;
		end else begin
			z80_rsp.valid <= 1'b0;
			zb_rsp.valid  <= 1'b0;

			if (zb_take) begin
				zsrc   <= SRC_MAIN;
				zaddr  <= zb_req.addr;
				zwdata <= zb_req.wdata;
				zwrite <= zb_req.write && free;
				state  <= ZB_READ;
			end else begin
				case (state)
					ZB_IDLE: begin
						if (z80_take && z80_req.addr[15]) begin
							// Window into 68000 space through the bank register
							win_req.valid <= 1'b1;
							win_req.write <= z80_req.write;
							win_req.ube   <= !z80_req.addr[0];
							win_req.lbe   <= z80_req.addr[0];
							win_req.addr  <= {bank, z80_req.addr[14:0]};
							win_req.wdata <= {2{z80_req.wdata}};
							state         <= ZB_WINDOW;
						end else if (z80_take) begin
							zsrc   <= SRC_Z80;
							zaddr  <= z80_req.addr[14:0];
							zwdata <= z80_req.wdata;
							zwrite <= z80_req.write;
							state  <= ZB_READ;
						end
					end

					ZB_READ: begin
						if (zwrite && bank_sel)
							bank <= {zwdata[0], bank[BANK_W-1:1]};
						state <= ZB_FINISH;
					end

					ZB_FINISH: begin
						if (zsrc == SRC_MAIN) begin
							zb_rsp.valid <= 1'b1;
							zb_rsp.rdata <= free ? rd_byte : 8'hFF;
							state        <= win_req.valid ? ZB_WINDOW : ZB_IDLE;
						end else begin
							z80_rsp.valid <= 1'b1;
							z80_rsp.rdata <= rd_byte;
							state         <= ZB_IDLE;
						end
					end

					default: begin
						if (win_req.valid && win_ready)
							win_req.valid <= 1'b0;
						if (win_rsp.valid) begin
							z80_rsp.valid <= 1'b1;
							z80_rsp.rdata <= win_req.addr[0] ? win_rsp.rdata[7:0]
								: win_rsp.rdata[15:8];
							state <= ZB_IDLE;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: tb.f
src/genesis_bus_pkg.sv
src/clk_enable_gen.sv
src/sync_ram.sv
src/mbus_fsm.sv
src/zbus_ctrl.sv
src/genesis_bus_top.sv
bench/tb_genesis_bus.sv
